//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cache_tb \
		-f files.f -o Vcache_tb
	-./obj_dir/Vcache_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "FAIL: run did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
src/cache_pkg.sv
src/cache_front_end.sv
src/cache_memory.sv
src/backing_ram.sv
src/cache_control.sv
src/cache_top.sv
testbench/cache_props.sv
testbench/cache_tb.sv

//--- src/backing_ram.sv
module backing_ram #(
   parameter int RAM_LATENCY = 3
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         ram_req_i,
   input  logic                         ram_we_i,
   input  logic [cache_pkg::ADDR_W-2:0] ram_addr_i,
   input  logic [cache_pkg::DATA_W-1:0] ram_wdata_i,
   input  logic [cache_pkg::STRB_W-1:0] ram_wstrb_i,
   output logic                         ram_ack_o,
   output logic [cache_pkg::DATA_W-1:0] ram_rdata_o
);

   localparam int WORDS = 2 ** (cache_pkg::ADDR_W - 1);
   localparam int CNT_W = $clog2(RAM_LATENCY + 1);

   logic [cache_pkg::DATA_W-1:0] mem [WORDS];
   logic                         busy_q;
   logic [CNT_W-1:0]             cnt_q;
   logic                         start;

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign start     = ram_req_i & ~busy_q;
   assign ram_ack_o = busy_q && (cnt_q == '0);

   // Ack when the latency counter reaches zero
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (start) begin
         busy_q <= 1'b1;
         cnt_q  <= CNT_W'(RAM_LATENCY - 1);
      end else if (busy_q) begin
         if (cnt_q == '0) begin
            busy_q <= 1'b0;
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         if (ram_we_i) begin
            mem[ram_addr_i] <= cache_pkg::merge_bytes(mem[ram_addr_i], ram_wdata_i,
                                                      ram_wstrb_i);
         end
         ram_rdata_o <= mem[ram_addr_i];
      end
   end

endmodule

//--- src/cache_control.sv
module cache_control (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  cache_pkg::cache_req_s   req_i,
   input  logic                    ctrl_req_i,
   input  cache_pkg::cache_event_s event_i,
   output cache_pkg::cache_rsp_s   rsp_o,
   output logic                    inv_o
);

   logic                         ack_q;
   logic [cache_pkg::DATA_W-1:0] rdata_q;
   logic [cache_pkg::DATA_W-1:0] hits_q;
   logic [cache_pkg::DATA_W-1:0] misses_q;
   logic [cache_pkg::DATA_W-1:0] writes_q;
   logic [cache_pkg::REG_W-1:0]  reg_sel;
   logic                         start;
   logic                         clear;

   // Counters stop at all ones
   function automatic logic [cache_pkg::DATA_W-1:0] sat_inc(
      input logic [cache_pkg::DATA_W-1:0] cnt,
      input logic                         en
   );
      return (en && cnt != '1) ? cnt + 1'b1 : cnt;
   endfunction

   assign reg_sel = req_i.addr.ctrl.reg_sel;
   assign start   = ctrl_req_i & ~ack_q;
   assign clear   = start & req_i.we & (reg_sel != cache_pkg::CTRL_INVALIDATE);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q    <= 1'b0;
         inv_o    <= 1'b0;
         hits_q   <= '0;
         misses_q <= '0;
         writes_q <= '0;
      end else begin
         ack_q <= start;
         inv_o <= start & req_i.we & (reg_sel == cache_pkg::CTRL_INVALIDATE);
         if (clear) begin
            hits_q   <= '0;
            misses_q <= '0;
            writes_q <= '0;
         end else begin
            hits_q   <= sat_inc(hits_q, event_i.read_hit);
            misses_q <= sat_inc(misses_q, event_i.read_miss);
            writes_q <= sat_inc(writes_q, event_i.write);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         case (reg_sel)
            cache_pkg::CTRL_HITS:   rdata_q <= hits_q;
            cache_pkg::CTRL_MISSES: rdata_q <= misses_q;
            cache_pkg::CTRL_WRITES: rdata_q <= writes_q;
            default:                rdata_q <= '0;
         endcase
      end
   end

   assign rsp_o.ack   = ack_q;
   assign rsp_o.rdata = rdata_q;

endmodule

//--- src/cache_front_end.sv
module cache_front_end (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         valid_i,
   input  cache_pkg::cache_addr_u       addr_i,
   input  logic [cache_pkg::DATA_W-1:0] wdata_i,
   input  logic [cache_pkg::STRB_W-1:0] wstrb_i,
   input  cache_pkg::cache_rsp_s        mem_rsp_i,
   input  cache_pkg::cache_rsp_s        ctrl_rsp_i,
   output logic                         ready_o,
   output logic                         rvalid_o,
   output logic [cache_pkg::DATA_W-1:0] rdata_o,
   output cache_pkg::cache_req_s        req_o,
   output logic                         mem_req_o,
   output logic                         ctrl_req_o
);

   logic ack;
   logic accept;

   assign ack = mem_rsp_i.ack | ctrl_rsp_i.ack;

   // Free when idle, or when the outstanding request completes now
   assign ready_o = ~(mem_req_o | ctrl_req_o) | ack;
   assign accept  = valid_i & ready_o;

   // Merge the two response paths
   assign rdata_o  = ctrl_rsp_i.ack ? ctrl_rsp_i.rdata : mem_rsp_i.rdata;
   assign rvalid_o = ack & ~req_o.we;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mem_req_o  <= 1'b0;
         ctrl_req_o <= 1'b0;
      end else if (accept) begin
         // Top address bit picks the part
         mem_req_o  <= ~addr_i.mem.ctrl_sel;
         ctrl_req_o <= addr_i.mem.ctrl_sel;
      end else if (ack) begin
         mem_req_o  <= 1'b0;
         ctrl_req_o <= 1'b0;
      end
   end

   // Held stable until the next acceptance
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_o.addr  <= addr_i;
         req_o.wdata <= wdata_i;
         req_o.wstrb <= wstrb_i;
         req_o.we    <= |wstrb_i;
      end
   end

endmodule

//--- src/cache_memory.sv
module cache_memory #(
   parameter int RAM_LATENCY = 3
) (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  cache_pkg::cache_req_s   req_i,
   input  logic                    mem_req_i,
   input  logic                    inv_i,
   output cache_pkg::cache_rsp_s   rsp_o,
   output cache_pkg::cache_event_s event_o
);

   localparam int LINES = 2 ** cache_pkg::INDEX_W;

   typedef enum logic [1:0] {
      S_IDLE,
      S_RAM,
      S_RESP
   } state_e;

   state_e                        state_q;
   logic [cache_pkg::TAG_W-1:0]   tag_mem  [LINES];
   logic [cache_pkg::DATA_W-1:0]  data_mem [LINES];
   logic [LINES-1:0]              valid_q;
   logic [cache_pkg::DATA_W-1:0]  rdata_q;
   logic                          hit_q;
   logic [cache_pkg::INDEX_W-1:0] index;
   logic                          hit;
   logic                          ram_req;
   logic                          ram_ack;
   logic [cache_pkg::DATA_W-1:0]  ram_rdata;

   assign index = req_i.addr.mem.index;
   assign hit   = valid_q[index] && (tag_mem[index] == req_i.addr.mem.tag);

   // Read misses and all writes go to the RAM
   assign ram_req = (state_q == S_IDLE && mem_req_i && (req_i.we || !hit)) ||
                    (state_q == S_RAM);

   backing_ram #(
      .RAM_LATENCY(RAM_LATENCY)
   ) u_backing_ram (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ram_req_i  (ram_req),
      .ram_we_i   (req_i.we),
      .ram_addr_i ({req_i.addr.mem.tag, req_i.addr.mem.index}),
      .ram_wdata_i(req_i.wdata),
      .ram_wstrb_i(req_i.wstrb),
      .ram_ack_o  (ram_ack),
      .ram_rdata_o(ram_rdata)
   );

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         valid_q <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (mem_req_i) begin
                  state_q <= (!req_i.we && hit) ? S_RESP : S_RAM;
               end
            end
            S_RAM: begin
               if (ram_ack) begin
                  state_q <= S_RESP;
               end
            end
            default: state_q <= S_IDLE;
         endcase
         if (inv_i) begin
            valid_q <= '0;
         end else if (state_q == S_RAM && ram_ack && !req_i.we) begin
            valid_q[index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && mem_req_i) begin
         hit_q   <= hit;
         rdata_q <= data_mem[index];
      end
      if (state_q == S_RAM && ram_ack) begin
         if (req_i.we) begin
            // Write hit keeps the line in step with the RAM
            if (hit) begin
               data_mem[index] <= cache_pkg::merge_bytes(data_mem[index], req_i.wdata,
                                                         req_i.wstrb);
            end
         end else begin
            tag_mem[index]  <= req_i.addr.mem.tag;
            data_mem[index] <= ram_rdata;
            rdata_q         <= ram_rdata;
         end
      end
   end

   assign rsp_o.ack   = (state_q == S_RESP);
   assign rsp_o.rdata = rdata_q;

   // One pulse per completed request, alongside the ack
   assign event_o.read_hit  = rsp_o.ack && !req_i.we && hit_q;
   assign event_o.read_miss = rsp_o.ack && !req_i.we && !hit_q;
   assign event_o.write     = rsp_o.ack && req_i.we;

endmodule

//--- src/cache_pkg.sv
package cache_pkg;

   localparam int ADDR_W  = 10;
   localparam int DATA_W  = 32;
   localparam int STRB_W  = DATA_W / 8;
   localparam int INDEX_W = 4;
   localparam int TAG_W   = ADDR_W - 1 - INDEX_W;
   localparam int REG_W   = 3;

   // Address as seen by the cache memory
   typedef struct packed {
      logic               ctrl_sel;
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
   } mem_view_s;

   // Address as seen by the control registers
   typedef struct packed {
      logic                    ctrl_sel;
      logic [ADDR_W-REG_W-2:0] unused;
      logic [REG_W-1:0]        reg_sel;
   } ctrl_view_s;

   typedef union packed {
      mem_view_s  mem;
      ctrl_view_s ctrl;
   } cache_addr_u;

   typedef struct packed {
      cache_addr_u       addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      logic              we;
   } cache_req_s;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] rdata;
   } cache_rsp_s;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write;
   } cache_event_s;

   localparam logic [REG_W-1:0] CTRL_HITS       = 3'd0;
   localparam logic [REG_W-1:0] CTRL_MISSES     = 3'd1;
   localparam logic [REG_W-1:0] CTRL_WRITES     = 3'd2;
   localparam logic [REG_W-1:0] CTRL_INVALIDATE = 3'd3;

   // Byte lanes with a strobe bit take the new value
   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word,
      input logic [STRB_W-1:0] strb
   );
      logic [DATA_W-1:0] word;
      word = old_word;
      for (int i = 0; i < STRB_W; i++) begin
         if (strb[i]) begin
            word[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return word;
   endfunction

endpackage

//--- src/cache_top.sv
module cache_top #(
   parameter int RAM_LATENCY = 3
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         valid_i,
   input  cache_pkg::cache_addr_u       addr_i,
   input  logic [cache_pkg::DATA_W-1:0] wdata_i,
   input  logic [cache_pkg::STRB_W-1:0] wstrb_i,
   output logic                         ready_o,
   output logic                         rvalid_o,
   output logic [cache_pkg::DATA_W-1:0] rdata_o
);

   cache_pkg::cache_req_s   req;
   cache_pkg::cache_rsp_s   mem_rsp;
   cache_pkg::cache_rsp_s   ctrl_rsp;
   cache_pkg::cache_event_s events;
   logic                    mem_req;
   logic                    ctrl_req;
   logic                    inv;

   cache_front_end u_front_end (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .valid_i   (valid_i),
      .addr_i    (addr_i),
      .wdata_i   (wdata_i),
      .wstrb_i   (wstrb_i),
      .mem_rsp_i (mem_rsp),
      .ctrl_rsp_i(ctrl_rsp),
      .ready_o   (ready_o),
      .rvalid_o  (rvalid_o),
      .rdata_o   (rdata_o),
      .req_o     (req),
      .mem_req_o (mem_req),
      .ctrl_req_o(ctrl_req)
   );

   cache_memory #(
      .RAM_LATENCY(RAM_LATENCY)
   ) u_memory (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (req),
      .mem_req_i(mem_req),
      .inv_i    (inv),
      .rsp_o    (mem_rsp),
      .event_o  (events)
   );

   cache_control u_control (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (req),
      .ctrl_req_i(ctrl_req),
      .event_i   (events),
      .rsp_o     (ctrl_rsp),
      .inv_o     (inv)
   );

endmodule

//--- testbench/cache_props.sv
module cache_props (
   input logic                  clk_i,
   input logic                  rst_i,
   input logic                  mem_req_i,
   input logic                  ctrl_req_i,
   input logic                  rvalid_i,
   input cache_pkg::cache_rsp_s mem_rsp_i,
   input cache_pkg::cache_rsp_s ctrl_rsp_i,
   input cache_pkg::cache_req_s req_i
);
   timeunit 1ns;
   timeprecision 1ps;

   mem_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_req_i && !mem_rsp_i.ack |=> mem_req_i)
      else $error("memory request line dropped before its ack");

   ctrl_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
      ctrl_req_i && !ctrl_rsp_i.ack |=> ctrl_req_i)
      else $error("control request line dropped before its ack");

   one_part: assert property (@(posedge clk_i) disable iff (rst_i)
      !(mem_req_i && ctrl_req_i))
      else $error("both request lines high together");

   no_rvalid_on_write: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_i |-> !req_i.we)
      else $error("rvalid_o high for a write");

   idle_after_reset: assert property (@(posedge clk_i)
      rst_i |=> !mem_req_i && !ctrl_req_i)
      else $error("request line high right after reset");

endmodule

bind cache_front_end cache_props u_props (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .mem_req_i (mem_req_o),
   .ctrl_req_i(ctrl_req_o),
   .rvalid_i  (rvalid_o),
   .mem_rsp_i (mem_rsp_i),
   .ctrl_rsp_i(ctrl_rsp_i),
   .req_i     (req_o)
);

//--- testbench/cache_tb.sv
module cache_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT = 60;

   typedef struct {
      string                        name;
      logic                         we;
      logic [cache_pkg::ADDR_W-1:0] addr;
      logic [cache_pkg::DATA_W-1:0] wdata;
      logic [cache_pkg::STRB_W-1:0] wstrb;
      logic [cache_pkg::DATA_W-1:0] exp;
      logic                         use_model;
   } row_t;

   logic                         clk_i = 1'b0;
   logic                         rst_i;
   logic                         valid_i;
   cache_pkg::cache_addr_u       addr_i;
   logic [cache_pkg::DATA_W-1:0] wdata_i;
   logic [cache_pkg::STRB_W-1:0] wstrb_i;
   logic                         ready_o;
   logic                         rvalid_o;
   logic [cache_pkg::DATA_W-1:0] rdata_o;

   row_t        rows[$];
   int          errors;
   int          checks;
   logic [31:0] lfsr;
   // Shadow memory, line state and counters
   logic [31:0] shadow [512];
   logic [15:0] line_valid;
   logic [4:0]  line_tag [16];
   logic [31:0] cnt_hits;
   logic [31:0] cnt_misses;
   logic [31:0] cnt_writes;

   cache_top #(
      .RAM_LATENCY(3)
   ) dut (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (valid_i),
      .addr_i  (addr_i),
      .wdata_i (wdata_i),
      .wstrb_i (wstrb_i),
      .ready_o (ready_o),
      .rvalid_o(rvalid_o),
      .rdata_o (rdata_o)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   // Expected read data from the models, then the model update
   task automatic model_op(input logic we, input logic [9:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, output logic [31:0] exp);
      logic [3:0] idx;
      logic [4:0] tag;
      logic       hit;
      idx = addr[3:0];
      tag = addr[8:4];
      hit = line_valid[idx] && (line_tag[idx] == tag);
      exp = '0;
      if (addr[9]) begin
         if (we && addr[2:0] == 3'd3) begin
            line_valid = '0;
         end else if (we) begin
            cnt_hits   = '0;
            cnt_misses = '0;
            cnt_writes = '0;
         end else begin
            case (addr[2:0])
               3'd0:    exp = cnt_hits;
               3'd1:    exp = cnt_misses;
               3'd2:    exp = cnt_writes;
               default: exp = '0;
            endcase
         end
      end else if (we) begin
         for (int i = 0; i < 4; i++) begin
            if (wstrb[i]) shadow[addr[8:0]][8*i +: 8] = wdata[8*i +: 8];
         end
         cnt_writes = cnt_writes + 1;
      end else begin
         exp = shadow[addr[8:0]];
         if (hit) begin
            cnt_hits = cnt_hits + 1;
         end else begin
            cnt_misses     = cnt_misses + 1;
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
         end
      end
   endtask

   task automatic run_op(input string name, input logic we, input logic [9:0] addr,
                         input logic [31:0] wdata, input logic [3:0] wstrb,
                         output logic [31:0] rdata);
      int   n;
      logic done;
      rdata = '0;
      @(posedge clk_i);
      valid_i <= 1'b1;
      addr_i  <= addr;
      wdata_i <= wdata;
      wstrb_i <= we ? wstrb : 4'h0;
      @(negedge clk_i);
      n = 0;
      while (!ready_o && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      if (!ready_o) begin
         errors++;
         $display("ERROR %s: ready_o stayed low, the request was never accepted", name);
      end
      // Accepted on this edge
      @(posedge clk_i);
      valid_i <= 1'b0;
      wstrb_i <= 4'h0;
      n = 0;
      done = 1'b0;
      while (!done && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
         if (we) begin
            if (rvalid_o) begin
               errors++;
               $display("ERROR %s: rvalid_o went high for a write", name);
            end
            if (ready_o) done = 1'b1;
         end else if (rvalid_o) begin
            rdata = rdata_o;
            done  = 1'b1;
         end
      end
      if (!done) begin
         errors++;
         $display("ERROR %s: no response from the cache before the timeout", name);
      end
   endtask

   initial begin
      logic [31:0] exp;
      logic [31:0] got;
      logic [31:0] b;
      logic        we;
      logic [9:0]  addr;
      logic [31:0] wdata;
      logic [3:0]  strb;
      valid_i    = 1'b0;
      addr_i     = '0;
      wdata_i    = '0;
      wstrb_i    = '0;
      rst_i      = 1'b1;
      errors     = 0;
      checks     = 0;
      lfsr       = 32'hc6b8;
      line_valid = '0;
      cnt_hits   = '0;
      cnt_misses = '0;
      cnt_writes = '0;
      for (int i = 0; i < 512; i++) shadow[i] = '0;
      for (int i = 0; i < 16; i++) line_tag[i] = '0;

      // name, we, addr, wdata, wstrb, expected, use model
      rows.push_back('{"wr_partial", 1'b1, 10'h015, 32'ha1b2c3d4, 4'b0101, 32'h0, 1'b0});
      rows.push_back('{"rd_merged_miss", 1'b0, 10'h015, 32'h0, 4'h0, 32'h00b200d4, 1'b0});
      rows.push_back('{"rd_hit", 1'b0, 10'h015, 32'h0, 4'h0, 32'h00b200d4, 1'b0});
      rows.push_back('{"rd_hits", 1'b0, 10'h200, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"rd_misses", 1'b0, 10'h201, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"wr_cached", 1'b1, 10'h015, 32'h11223344, 4'b1100, 32'h0, 1'b0});
      rows.push_back('{"rd_updated_hit", 1'b0, 10'h015, 32'h0, 4'h0, 32'h112200d4, 1'b0});
      rows.push_back('{"rd_hits_2", 1'b0, 10'h200, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"wr_invalidate", 1'b1, 10'h203, 32'h1, 4'b0001, 32'h0, 1'b0});
      rows.push_back('{"rd_after_inv", 1'b0, 10'h015, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"rd_misses_2", 1'b0, 10'h201, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"rd_conflict", 1'b0, 10'h025, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"rd_evicted", 1'b0, 10'h015, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"rd_misses_3", 1'b0, 10'h201, 32'h0, 4'h0, 32'h0, 1'b1});
      rows.push_back('{"rd_writes", 1'b0, 10'h202, 32'h0, 4'h0, 32'h0, 1'b1});
      // All counters are nonzero here
      rows.push_back('{"rd_inv_reg", 1'b0, 10'h203, 32'h0, 4'h0, 32'h0, 1'b0});
      rows.push_back('{"wr_clear", 1'b1, 10'h200, 32'h0, 4'b1111, 32'h0, 1'b0});
      rows.push_back('{"rd_writes_zero", 1'b0, 10'h202, 32'h0, 4'h0, 32'h0, 1'b0});

      repeat (8) @(posedge clk_i);
      rst_i <= 1'b0;

      foreach (rows[i]) begin
         model_op(rows[i].we, rows[i].addr, rows[i].wdata, rows[i].wstrb, exp);
         run_op(rows[i].name, rows[i].we, rows[i].addr, rows[i].wdata, rows[i].wstrb, got);
         if (!rows[i].we) check(rows[i].name, rows[i].use_model ? exp : rows[i].exp, got);
      end

      // Random traffic over the low 64 words, so lines get reused
      for (int k = 0; k < 40; k++) begin
         take_bits(1, b);
         we = b[0];
         take_bits(6, b);
         addr = {4'h0, b[5:0]};
         take_bits(4, b);
         strb = (b[3:0] == 4'h0) ? 4'hf : b[3:0];
         take_bits(32, b);
         wdata = b;
         model_op(we, addr, wdata, strb, exp);
         run_op($sformatf("rand_%0d", k), we, addr, wdata, strb, got);
         if (!we) check($sformatf("rand_%0d", k), exp, got);
      end

      for (int k = 0; k < 3; k++) begin
         addr = {7'h40, 3'(k)};
         model_op(1'b0, addr, 32'h0, 4'h0, exp);
         run_op($sformatf("final_count_%0d", k), 1'b0, addr, 32'h0, 4'h0, got);
         check($sformatf("final_count_%0d", k), exp, got);
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
